// File: mips_debug_pkg.sv
package mips_debug_pkg;

  ////////////////////
  // widths

  localparam int byte_w           = 8;   // uart data
  localparam int instr_w          = 32;
  localparam int addr_w_default   = 7;   // instruction memory depth 128
  localparam int bucket_w_default = 32;  // whole bytes only

  ////////////////////
  // command bytes from the host

  localparam logic [byte_w-1:0] cmd_start      = 8'd1;
  localparam logic [byte_w-1:0] cmd_continuous = 8'd2;
  localparam logic [byte_w-1:0] cmd_step_mode  = 8'd3;
  localparam logic [byte_w-1:0] cmd_reprogram  = 8'd5;
  localparam logic [byte_w-1:0] cmd_step       = 8'd6;

  // opcode of the last program word
  localparam logic [5:0] halt_opcode = 6'b111111;

  ////////////////////
  // instruction word filled byte by byte and read back as opcode

  typedef union packed {
    logic [instr_w/byte_w-1:0][byte_w-1:0] bytes;  // bytes[0] is the lsb
    struct packed {
      logic [5:0]         opcode;
      logic [instr_w-7:0] rest;
    } fields;
  } instr_word_u;

endpackage

// File: debug_control.sv
`timescale 1ns/1ps

module debug_control import mips_debug_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              halt,
  input  logic              rx_done_tick,
  input  logic [byte_w-1:0] rx_data,
  input  logic              word_done,
  input  logic              last_word,
  input  logic              send_done,
  output logic              load_clear,
  output logic              load_byte,
  output logic              send_start,
  output logic              ctrl_clk_mips,
  output logic              debug
);

  ////////////////////
  // mode states

  localparam logic [2:0] st_idle        = 3'd0;
  localparam logic [2:0] st_programming = 3'd1;
  localparam logic [2:0] st_waiting     = 3'd2;
  localparam logic [2:0] st_step        = 3'd3;
  localparam logic [2:0] st_sending     = 3'd4;
  localparam logic [2:0] st_continuous  = 3'd5;

  logic [2:0] state;
  logic [2:0] state_next;

  logic rx_tick_q;  // previous rx_done_tick
  logic rx_edge;

  // a level-style tick from the receiver counts once
  assign rx_edge = rx_done_tick & ~rx_tick_q;

  ////////////////////
  // registers

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= st_idle;
      rx_tick_q  <= 1'b0;
      send_start <= 1'b0;
    end
    else
    begin
      state     <= state_next;
      rx_tick_q <= rx_done_tick;
      // high in the first cycle spent in sending
      send_start <= (state_next == st_sending) && (state != st_sending);
    end
  end

  ////////////////////
  // next state and strobes

  always_comb
  begin
    state_next    = state;
    load_clear    = 1'b0;
    load_byte     = 1'b0;
    ctrl_clk_mips = 1'b0;

    case (state)
      st_idle:
      begin
        if (rx_edge && (rx_data == cmd_start))
        begin
          state_next = st_programming;
          load_clear = 1'b1;  // address back to 0
        end
      end

      st_programming:
      begin
        load_byte = rx_edge;
        if (word_done && last_word)
        begin
          state_next = st_waiting;  // halt word went out
        end
      end

      st_waiting:
      begin
        if (rx_edge)
        begin
          case (rx_data)
            cmd_reprogram:
              state_next = st_idle;
            cmd_continuous:
              state_next = st_continuous;
            cmd_step_mode:
              state_next = st_step;
            default:
              state_next = st_idle;  // unknown command drops back
          endcase
        end
      end

      st_step:
      begin
        // anything but a step byte is ignored here
        if (rx_edge && (rx_data == cmd_step))
        begin
          ctrl_clk_mips = 1'b1;  // single core cycle
          state_next    = st_sending;
        end
      end

      st_continuous:
      begin
        ctrl_clk_mips = 1'b1;
        if (halt)
        begin
          state_next = st_sending;
        end
      end

      st_sending:
      begin
        if (send_done)
        begin
          // a halted core has nothing left to step
          state_next = halt ? st_waiting : st_step;
        end
      end

      default:
      begin
        state_next = st_idle;
      end
    endcase
  end

  assign debug = (state == st_programming);

endmodule

// File: program_loader.sv
`timescale 1ns/1ps

module program_loader import mips_debug_pkg::*;
#(
  parameter int addr_w = addr_w_default
)
(
  input  logic               clk,
  input  logic               reset,
  input  logic               load_clear,
  input  logic               load_byte,
  input  logic [byte_w-1:0]  rx_data,
  output logic [addr_w-1:0]  addr_mem_inst,
  output logic [instr_w-1:0] ins_to_mem,
  output logic               wr_ram_inst,
  output logic               word_done,
  output logic               last_word
);

  logic [1:0]  byte_idx;  // next byte slot counting from the lsb
  instr_word_u asm_word;  // word under assembly

  ////////////////////
  // byte index, write strobe, address

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      byte_idx      <= 2'd0;
      wr_ram_inst   <= 1'b0;
      addr_mem_inst <= '0;
    end
    else if (load_clear)
    begin
      byte_idx      <= 2'd0;
      wr_ram_inst   <= 1'b0;
      addr_mem_inst <= '0;
    end
    else
    begin
      // fourth byte completes the word and the write follows a cycle later
      wr_ram_inst <= load_byte && (byte_idx == 2'd3);

      if (load_byte)
      begin
        byte_idx <= byte_idx + 2'd1;  // wraps to 0 after the msb
      end

      // step on the edge that ends the write pulse
      if (wr_ram_inst)
      begin
        addr_mem_inst <= addr_mem_inst + 1'b1;
      end
    end
  end

  ////////////////////
  // word assembly

  always_ff @(posedge clk)
  begin
    if (load_byte)
    begin
      asm_word.bytes[byte_idx] <= rx_data;
    end
  end

  assign ins_to_mem = asm_word;
  assign word_done  = wr_ram_inst;

  // opcode view of the same word
  assign last_word = (asm_word.fields.opcode == halt_opcode);

endmodule

// File: bucket_sender.sv
`timescale 1ns/1ps

module bucket_sender import mips_debug_pkg::*;
#(
  parameter int bucket_w = bucket_w_default
)
(
  input  logic                clk,
  input  logic                reset,
  input  logic                send_start,
  input  logic [bucket_w-1:0] bucket,
  input  logic                tx_done_tick,
  output logic                tx_start,
  output logic [byte_w-1:0]   data_out,
  output logic                send_done
);

  localparam int n_bytes = bucket_w / byte_w;
  localparam int cnt_w   = (n_bytes > 1) ? $clog2(n_bytes) : 1;

  logic [bucket_w-1:0] shift_q;    // captured bucket with the wire byte at the bottom
  logic [cnt_w-1:0]    byte_cnt;   // bytes already sent
  logic                tx_tick_q;
  logic                tx_edge;
  logic                last_byte;

  assign tx_edge   = tx_done_tick & ~tx_tick_q & tx_start;
  assign last_byte = (byte_cnt == cnt_w'(n_bytes - 1));

  ////////////////////
  // control

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tx_start  <= 1'b0;
      send_done <= 1'b0;
      byte_cnt  <= '0;
      tx_tick_q <= 1'b0;
    end
    else
    begin
      tx_tick_q <= tx_done_tick;
      send_done <= 1'b0;
      if (send_start)
      begin
        tx_start <= 1'b1;
        byte_cnt <= '0;
      end
      else if (tx_edge)
      begin
        if (last_byte)
        begin
          tx_start  <= 1'b0;
          send_done <= 1'b1;
        end
        else
        begin
          byte_cnt <= byte_cnt + 1'b1;
        end
      end
    end
  end

  ////////////////////
  // payload

  always_ff @(posedge clk)
  begin
    if (send_start)
    begin
      shift_q <= bucket;  // snapshot of core state
    end
    else if (tx_edge)
    begin
      shift_q <= shift_q >> byte_w;  // next byte down once the current one is done
    end
  end

  assign data_out = shift_q[byte_w-1:0];

endmodule

// File: mips_debug_unit.sv
`timescale 1ns/1ps

module mips_debug_unit import mips_debug_pkg::*;
#(
  parameter int addr_w   = addr_w_default,
  parameter int bucket_w = bucket_w_default
)
(
  input  logic                clk,
  input  logic                reset,
  input  logic                halt,
  input  logic [bucket_w-1:0] bucket,
  input  logic                rx_done_tick,
  input  logic [byte_w-1:0]   rx_data,
  input  logic                tx_done_tick,
  output logic [addr_w-1:0]   addr_mem_inst,
  output logic [instr_w-1:0]  ins_to_mem,
  output logic                wr_ram_inst,
  output logic                ctrl_clk_mips,
  output logic                debug,
  output logic                tx_start,
  output logic [byte_w-1:0]   data_out
);

  // control to datapath strobes
  logic load_clear;
  logic load_byte;
  logic send_start;

  // datapath status back to control
  logic word_done;
  logic last_word;
  logic send_done;

  debug_control debug_control_i (
    .clk           (clk),
    .reset         (reset),
    .halt          (halt),
    .rx_done_tick  (rx_done_tick),
    .rx_data       (rx_data),
    .word_done     (word_done),
    .last_word     (last_word),
    .send_done     (send_done),
    .load_clear    (load_clear),
    .load_byte     (load_byte),
    .send_start    (send_start),
    .ctrl_clk_mips (ctrl_clk_mips),
    .debug         (debug)
  );

  program_loader #(
    .addr_w (addr_w)
  ) program_loader_i (
    .clk           (clk),
    .reset         (reset),
    .load_clear    (load_clear),
    .load_byte     (load_byte),
    .rx_data       (rx_data),
    .addr_mem_inst (addr_mem_inst),
    .ins_to_mem    (ins_to_mem),
    .wr_ram_inst   (wr_ram_inst),
    .word_done     (word_done),
    .last_word     (last_word)
  );

  bucket_sender #(
    .bucket_w (bucket_w)
  ) bucket_sender_i (
    .clk          (clk),
    .reset        (reset),
    .send_start   (send_start),
    .bucket       (bucket),
    .tx_done_tick (tx_done_tick),
    .tx_start     (tx_start),
    .data_out     (data_out),
    .send_done    (send_done)
  );

endmodule

// File: debug_checker.sv
`timescale 1ns/1ps

module debug_checker
(
  input logic clk,
  input logic reset,
  input logic wr_ram_inst,
  input logic ctrl_clk_mips,
  input logic debug,
  input logic tx_start
);

  int fail_count = 0;

  // write strobe lasts one cycle
  wr_single: assert property (@(posedge clk) disable iff (reset)
    wr_ram_inst |=> !wr_ram_inst)
    else
    begin
      fail_count++;
      $error("wr_ram_inst high in two consecutive cycles");
    end

  wr_in_debug: assert property (@(posedge clk) disable iff (reset)
    wr_ram_inst |-> debug)
    else
    begin
      fail_count++;
      $error("wr_ram_inst high outside programming");
    end

  // core runs and tx never overlap
  run_or_send: assert property (@(posedge clk) disable iff (reset)
    !(tx_start && ctrl_clk_mips))
    else
    begin
      fail_count++;
      $error("tx_start and ctrl_clk_mips high together");
    end

  send_no_debug: assert property (@(posedge clk) disable iff (reset)
    tx_start |-> !debug)
    else
    begin
      fail_count++;
      $error("debug high while tx_start is high");
    end

endmodule

// File: debug_monitor.sv
`timescale 1ns/1ps

module debug_monitor import mips_debug_pkg::*;
#(
  parameter int addr_w = addr_w_default
)
(
  input logic               clk,
  input logic               reset,
  input logic               wr_ram_inst,
  input logic [addr_w-1:0]  addr_mem_inst,
  input logic [instr_w-1:0] ins_to_mem,
  input logic               ctrl_clk_mips,
  input logic               debug,
  input logic               tx_done_tick,
  input logic [byte_w-1:0]  data_out
);

  logic [addr_w-1:0] exp_addr[$];
  instr_word_u       exp_word[$];
  logic [addr_w-1:0] got_addr[$];
  instr_word_u       got_word[$];
  logic [byte_w-1:0] exp_tx[$];
  logic [byte_w-1:0] got_tx[$];

  logic tx_tick_q;
  int   clk_en_cycles = 0;
  int   wr_errors = 0;
  int   tx_errors = 0;
  int   clk_errors = 0;
  int   debug_errors = 0;
  int   missing_errors = 0;

  // pair up seen and expected items in order
  task automatic compare_queues();
    logic [addr_w-1:0] ea;
    instr_word_u       ew;
    logic [byte_w-1:0] eb;
    while (exp_addr.size() > 0 && got_addr.size() > 0)
    begin
      ea = exp_addr.pop_front();
      ew = exp_word.pop_front();
      if (got_addr[0] !== ea)
      begin
        wr_errors++;
        $display("ERROR %0t addr_mem_inst got %h expected %h", $time, got_addr[0], ea);
      end
      if (got_word[0] !== ew)
      begin
        wr_errors++;
        $display("ERROR %0t ins_to_mem got %h expected %h", $time, got_word[0], ew);
      end
      void'(got_addr.pop_front());
      void'(got_word.pop_front());
    end
    while (exp_tx.size() > 0 && got_tx.size() > 0)
    begin
      eb = exp_tx.pop_front();
      if (got_tx[0] !== eb)
      begin
        tx_errors++;
        $display("ERROR %0t data_out got %h expected %h", $time, got_tx[0], eb);
      end
      void'(got_tx.pop_front());
    end
  endtask

  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (wr_ram_inst)
      begin
        got_addr.push_back(addr_mem_inst);
        got_word.push_back(ins_to_mem);
      end
      if (tx_done_tick && !tx_tick_q)
        got_tx.push_back(data_out);  // byte on offer at the done edge
      if (ctrl_clk_mips)
        clk_en_cycles++;
      compare_queues();
    end
    tx_tick_q <= tx_done_tick;
  end

  task automatic expect_write(input logic [addr_w-1:0] a, input instr_word_u w);
    exp_addr.push_back(a);
    exp_word.push_back(w);
    compare_queues();
  endtask

  task automatic expect_tx(input logic [byte_w-1:0] b);
    exp_tx.push_back(b);
    compare_queues();
  endtask

  function automatic int pending_tx();
    return exp_tx.size();
  endfunction

  task automatic check_clk_en(input int expected, input bit at_least);
    if (at_least ? (clk_en_cycles < expected) : (clk_en_cycles != expected))
    begin
      clk_errors++;
      $display("ERROR %0t ctrl_clk_mips got %0d cycles expected %s%0d", $time,
               clk_en_cycles, at_least ? "at least " : "", expected);
    end
    clk_en_cycles = 0;  // count restarts per check
  endtask

  task automatic check_debug(input logic expected);
    if (debug !== expected)
    begin
      debug_errors++;
      $display("ERROR %0t debug got %b expected %b", $time, debug, expected);
    end
  endtask

  ////////////////////
  // leftovers at the end

  task automatic final_report();
    if (exp_addr.size() > 0)
      $display("%0d expected instruction writes never happened", exp_addr.size());
    if (got_addr.size() > 0)
      $display("%0d instruction writes happened that were not expected", got_addr.size());
    if (exp_tx.size() > 0)
      $display("%0d expected tx bytes were never sent", exp_tx.size());
    if (got_tx.size() > 0)
      $display("%0d tx bytes were sent that were not expected", got_tx.size());
    missing_errors += exp_addr.size() + got_addr.size() + exp_tx.size() + got_tx.size();
  endtask

  function automatic int error_total();
    return wr_errors + tx_errors + clk_errors + debug_errors + missing_errors;
  endfunction

endmodule

// File: tb_mips_debug.sv
`timescale 1ns/1ps

module tb_mips_debug import mips_debug_pkg::*;
();

  localparam int addr_w   = addr_w_default;
  localparam int bucket_w = bucket_w_default;

  // row kinds
  localparam int k_rx      = 0;  // one byte over rx
  localparam int k_word    = 1;  // four bytes lsb first
  localparam int k_halt    = 2;
  localparam int k_bucket  = 3;
  localparam int k_dump    = 4;  // expect the bucket on tx and wait for it
  localparam int k_wait    = 5;
  localparam int k_clk     = 6;  // clock enable cycles since last check
  localparam int k_clk_min = 7;
  localparam int k_debug   = 8;

  localparam logic [31:0] prog_w0 = 32'h2001_0005;
  localparam logic [31:0] prog_w1 = 32'h2002_000a;
  localparam logic [31:0] prog_w2 = 32'h0022_1820;
  localparam logic [31:0] prog_w3 = {halt_opcode, 26'd0};
  localparam logic [31:0] prog_w4 = {halt_opcode, 26'h01e_0042};

  ////////////////////
  // stimulus table

  localparam int n_rows = 48;
  localparam logic [31:0] stim [n_rows][2] = '{
    // idle after reset then a stray byte
    '{k_wait, 5}, '{k_debug, 0}, '{k_clk, 0}, '{k_rx, 8'h77}, '{k_debug, 0},
    // three words then the halt word
    '{k_rx, cmd_start}, '{k_debug, 1}, '{k_word, prog_w0}, '{k_word, prog_w1},
    '{k_word, prog_w2}, '{k_debug, 1}, '{k_word, prog_w3}, '{k_wait, 2}, '{k_debug, 0},
    // step mode with two steps and a stray byte
    '{k_bucket, 32'h1234_5678}, '{k_rx, cmd_step_mode}, '{k_clk, 0}, '{k_rx, cmd_step},
    '{k_dump, 0}, '{k_clk, 1},
    '{k_bucket, 32'hcafe_0b0e}, '{k_rx, cmd_step}, '{k_dump, 0}, '{k_clk, 1},
    '{k_rx, 8'h42}, '{k_wait, 4}, '{k_clk, 0},
    // last step with halt set returns to waiting
    '{k_halt, 1}, '{k_rx, cmd_step}, '{k_dump, 0}, '{k_clk, 1},
    // continuous run until halt
    '{k_halt, 0}, '{k_bucket, 32'h0bad_f00d}, '{k_rx, cmd_continuous}, '{k_wait, 20},
    '{k_halt, 1}, '{k_dump, 0}, '{k_clk_min, 20},
    // reprogram with a single halt word
    '{k_rx, cmd_reprogram}, '{k_rx, cmd_start}, '{k_debug, 1}, '{k_word, prog_w4},
    '{k_wait, 2}, '{k_debug, 0}, '{k_rx, 8'h09}, '{k_rx, 8'h21}, '{k_wait, 5}, '{k_clk, 0}
  };

  // address and word pairs
  localparam logic [31:0] wr_tbl [5][2] = '{
    '{0, prog_w0}, '{1, prog_w1}, '{2, prog_w2}, '{3, prog_w3}, '{0, prog_w4}
  };

  logic                clk;
  logic                reset;
  logic                halt;
  logic [bucket_w-1:0] bucket;
  logic                rx_done_tick;
  logic [byte_w-1:0]   rx_data;
  logic                tx_done_tick;
  logic [addr_w-1:0]   addr_mem_inst;
  logic [instr_w-1:0]  ins_to_mem;
  logic                wr_ram_inst;
  logic                ctrl_clk_mips;
  logic                debug;
  logic                tx_start;
  logic [byte_w-1:0]   data_out;

  integer rx_seed = 32'ha389_49e5;
  integer tx_seed = 32'ha389_49e5;

  int table_errors = 0;

  mips_debug_unit #(
    .addr_w   (addr_w),
    .bucket_w (bucket_w)
  ) mips_debug_unit_i (
    .clk           (clk),
    .reset         (reset),
    .halt          (halt),
    .bucket        (bucket),
    .rx_done_tick  (rx_done_tick),
    .rx_data       (rx_data),
    .tx_done_tick  (tx_done_tick),
    .addr_mem_inst (addr_mem_inst),
    .ins_to_mem    (ins_to_mem),
    .wr_ram_inst   (wr_ram_inst),
    .ctrl_clk_mips (ctrl_clk_mips),
    .debug         (debug),
    .tx_start      (tx_start),
    .data_out      (data_out)
  );

  debug_monitor #(
    .addr_w (addr_w)
  ) debug_monitor_i (
    .clk           (clk),
    .reset         (reset),
    .wr_ram_inst   (wr_ram_inst),
    .addr_mem_inst (addr_mem_inst),
    .ins_to_mem    (ins_to_mem),
    .ctrl_clk_mips (ctrl_clk_mips),
    .debug         (debug),
    .tx_done_tick  (tx_done_tick),
    .data_out      (data_out)
  );

  bind mips_debug_unit debug_checker debug_checker_i (
    .clk           (clk),
    .reset         (reset),
    .wr_ram_inst   (wr_ram_inst),
    .ctrl_clk_mips (ctrl_clk_mips),
    .debug         (debug),
    .tx_start      (tx_start)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // uart models

  task automatic send_byte(input logic [byte_w-1:0] b);
    int gap;
    @(negedge clk);
    rx_data      = b;
    rx_done_tick = 1'b1;
    @(negedge clk);
    rx_done_tick = 1'b0;
    gap = 2 + $unsigned($random(rx_seed)) % 5;  // 2..6 idle cycles
    repeat (gap) @(negedge clk);
  endtask

  // answer each offered byte after 3..8 cycles
  initial
  begin
    int delay;
    forever
    begin
      @(negedge clk);
      if (tx_start)
      begin
        delay = 3 + $unsigned($random(tx_seed)) % 6;
        repeat (delay - 1) @(negedge clk);
        tx_done_tick = 1'b1;
        @(negedge clk);
        tx_done_tick = 1'b0;
      end
    end
  end

  task automatic wait_dump();
    for (int i = 0; i < bucket_w / byte_w; i++)
      debug_monitor_i.expect_tx(bucket[i*byte_w +: byte_w]);  // lsb byte first
    while (debug_monitor_i.pending_tx() != 0)
      @(negedge clk);
    while (tx_start)
      @(negedge clk);
    repeat (3) @(negedge clk);  // let the fsm leave sending
  endtask

  task automatic apply_row(input logic [31:0] kind, input logic [31:0] val);
    case (kind)
      k_rx:      send_byte(val[byte_w-1:0]);
      k_word:    for (int i = 0; i < 4; i++) send_byte(val[8*i +: 8]);
      k_halt:    halt = val[0];
      k_bucket:  bucket = val[bucket_w-1:0];
      k_dump:    wait_dump();
      k_wait:    repeat (val) @(negedge clk);
      k_clk:     debug_monitor_i.check_clk_en(val, 1'b0);
      k_clk_min: debug_monitor_i.check_clk_en(val, 1'b1);
      k_debug:   debug_monitor_i.check_debug(val[0]);
      default:
      begin
        table_errors++;
        $display("unknown row kind %0d in the stimulus table", kind);
      end
    endcase
  endtask

  ////////////////////
  // main sequence

  initial
  begin
    int total;
    reset        = 1'b1;
    halt         = 1'b0;
    bucket       = '0;
    rx_done_tick = 1'b0;
    rx_data      = '0;
    tx_done_tick = 1'b0;
    for (int i = 0; i < 5; i++)
      debug_monitor_i.expect_write(wr_tbl[i][0][addr_w-1:0], wr_tbl[i][1]);
    repeat (10) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < n_rows; i++)
      apply_row(stim[i][0], stim[i][1]);
    repeat (5) @(negedge clk);
    debug_monitor_i.final_report();
    total = debug_monitor_i.error_total() + mips_debug_unit_i.debug_checker_i.fail_count
            + table_errors;
    $display("errors: wr %0d, tx %0d, clk %0d, debug %0d, missing %0d, assert %0d, table %0d",
             debug_monitor_i.wr_errors, debug_monitor_i.tx_errors,
             debug_monitor_i.clk_errors, debug_monitor_i.debug_errors,
             debug_monitor_i.missing_errors, mips_debug_unit_i.debug_checker_i.fail_count,
             table_errors);
    if (total == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (n_rows * 200 + 1000) @(posedge clk);
    $display("timeout: the test sequence did not finish in %0d cycles", n_rows * 200 + 1000);
    $display("sim failed");
    $finish;
  end

endmodule

// File: mips_debug.f
mips_debug_pkg.sv
debug_control.sv
program_loader.sv
bucket_sender.sv
mips_debug_unit.sv
debug_checker.sv
debug_monitor.sv
tb_mips_debug.sv
